// ==== Makefile ====
# Verilator build and run for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/csr_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "csr_macros.svh"

module csr_tb;
    import csr_pkg::*;

    localparam int ACK_TIMEOUT  = 16;
    localparam int POLL_TIMEOUT = 200;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    csr_addr_t   wb_adr;
    csr_data_t   wb_dat_w;
    csr_data_t   wb_dat_r;
    logic        wb_ack;
    logic        exc_valid;
    ecode_t      exc_ecode;
    esubcode_t   exc_esubcode;
    csr_data_t   exc_pc;
    csr_data_t   exc_badv;
    logic        exc_badv_valid;
    logic        ertn;
    logic [7:0]  hwi;
    logic        ipi;
    logic        irq_pending;
    logic [1:0]  plv;
    csr_data_t   era;
    csr_data_t   eentry;
    csr_data_t   tid;
    logic [63:0] stable_counter;

    int mismatch_count;
    int timeout_count;

    csr_addr_t mapped_addrs [16] = '{
        `CSR_CRMD, `CSR_PRMD, `CSR_EUEN, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_BADV,
        `CSR_EENTRY, `CSR_ASID, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
        `CSR_TID, `CSR_CPUID, `CSR_TCFG
    };

    csr_top uut (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .exc_valid      (exc_valid),
        .exc_ecode      (exc_ecode),
        .exc_esubcode   (exc_esubcode),
        .exc_pc         (exc_pc),
        .exc_badv       (exc_badv),
        .exc_badv_valid (exc_badv_valid),
        .ertn           (ertn),
        .hwi            (hwi),
        .ipi            (ipi),
        .irq_pending    (irq_pending),
        .plv            (plv),
        .era            (era),
        .eentry         (eentry),
        .tid            (tid),
        .stable_counter (stable_counter)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    // writable bits per register; CPUID reads back its fixed value instead
    function automatic csr_data_t writable_mask(input csr_addr_t addr);
        case (addr)
            `CSR_CRMD:   return 32'h0000_01ff;
            `CSR_PRMD:   return 32'h0000_0007;
            `CSR_EUEN:   return 32'h0000_0001;
            `CSR_ECFG:   return 32'h0000_1fff;
            `CSR_ESTAT:  return 32'h0000_0003;
            `CSR_EENTRY: return 32'hffff_ffc0;
            `CSR_ASID:   return 32'h0000_03ff;
            default:     return 32'hffff_ffff;
        endcase
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        assert (actual === expected)
        else
        begin
            $display("mismatch at %0d ns: %s read 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            mismatch_count++;
        end
    endtask

    // called on a falling edge, returns on the falling edge that sees the ack
    task automatic wb_write(input csr_addr_t addr, input csr_data_t data);
        int waited;
        begin
            waited   = 0;
            wb_cyc   = 1'b1;
            wb_stb   = 1'b1;
            wb_we    = 1'b1;
            wb_adr   = addr;
            wb_dat_w = data;
            @(negedge clk);
            while (!wb_ack && waited < ACK_TIMEOUT)
            begin
                @(negedge clk);
                waited++;
            end
            if (!wb_ack)
            begin
                $display("timeout: no ack for the write to address 0x%0h", addr);
                timeout_count++;
            end
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic wb_read(input csr_addr_t addr, output csr_data_t data);
        int waited;
        begin
            waited = 0;
            data   = '0;
            wb_cyc = 1'b1;
            wb_stb = 1'b1;
            wb_we  = 1'b0;
            wb_adr = addr;
            @(negedge clk);
            while (!wb_ack && waited < ACK_TIMEOUT)
            begin
                @(negedge clk);
                waited++;
            end
            if (!wb_ack)
            begin
                $display("timeout: no ack for the read of address 0x%0h", addr);
                timeout_count++;
            end
            else
                data = wb_dat_r;
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
        end
    endtask

    task automatic wait_estat_bit(input int bit_index, input string what);
        csr_data_t value;
        int        polls;
        begin
            polls = 0;
            wb_read(`CSR_ESTAT, value);
            while (!value[bit_index] && polls < POLL_TIMEOUT)
            begin
                wb_read(`CSR_ESTAT, value);
                polls++;
            end
            if (!value[bit_index])
            begin
                $display("timeout: ESTAT bit %0d never set while waiting for the %s",
                         bit_index, what);
                timeout_count++;
            end
        end
    endtask

    initial
    begin
        csr_data_t   rdata;
        csr_data_t   wdata;
        csr_data_t   expected;
        csr_data_t   eentry_exp;
        ecode_t      ecode;
        esubcode_t   esubcode;
        csr_data_t   pc;
        csr_data_t   badv;
        logic [7:0]  hwi_val;
        logic [63:0] count_start;
        int          gap;

        void'($urandom(32'ha133_6a8a));
        mismatch_count = 0;
        timeout_count  = 0;
        eentry_exp     = '0;
        rst            = 1'b1;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        exc_valid      = 1'b0;
        exc_ecode      = '0;
        exc_esubcode   = '0;
        exc_pc         = '0;
        exc_badv       = '0;
        exc_badv_valid = 1'b0;
        ertn           = 1'b0;
        hwi            = 8'b0;
        ipi            = 1'b0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset values
        check_value(irq_pending, 1'b0, "irq_pending after reset");
        check_value(wb_ack, 1'b0, "wb_ack after reset");
        wb_read(`CSR_CRMD, rdata);
        check_value(rdata, 32'h8, "CRMD after reset");
        wb_read(`CSR_PRMD, rdata);
        check_value(rdata, 32'h0, "PRMD after reset");
        wb_read(`CSR_ECFG, rdata);
        check_value(rdata, 32'h0, "ECFG after reset");
        wb_read(`CSR_ESTAT, rdata);
        check_value(rdata, 32'h0, "ESTAT after reset");
        wb_read(`CSR_TCFG, rdata);
        check_value(rdata, 32'h0, "TCFG after reset");
        wb_read(`CSR_TID, rdata);
        check_value(rdata, 32'h0, "TID after reset");
        wb_read(`CSR_CPUID, rdata);
        check_value(rdata, `CSR_CPUID_VALUE, "CPUID after reset");

        // write masks; TCFG goes last with the enable bit clear so the timer stays idle
        foreach (mapped_addrs[i])
        begin
            wdata = $urandom;
            if (mapped_addrs[i] == `CSR_TCFG)
                wdata[0] = 1'b0;
            if (mapped_addrs[i] == `CSR_CPUID)
                expected = `CSR_CPUID_VALUE;
            else
                expected = wdata & writable_mask(mapped_addrs[i]);
            if (mapped_addrs[i] == `CSR_EENTRY)
                eentry_exp = expected;
            wb_write(mapped_addrs[i], wdata);
            wb_read(mapped_addrs[i], rdata);
            check_value(rdata, expected, $sformatf("readback of 0x%0h", mapped_addrs[i]));
            if (mapped_addrs[i] == `CSR_TID)
                check_value(tid, expected, "tid output");
        end
        wb_write(14'h3ff, $urandom);
        wb_read(14'h3ff, rdata);
        check_value(rdata, 32'h0, "unmapped read");

        // exception entry and return
        wb_write(`CSR_PRMD, 32'h0);
        wb_write(`CSR_CRMD, 32'h7);
        ecode          = 6'($urandom);
        esubcode       = 9'($urandom);
        pc             = $urandom;
        badv           = $urandom;
        exc_ecode      = ecode;
        exc_esubcode   = esubcode;
        exc_pc         = pc;
        exc_badv       = badv;
        exc_badv_valid = 1'b1;
        exc_valid      = 1'b1;
        @(negedge clk);
        exc_valid      = 1'b0;
        exc_badv_valid = 1'b0;
        wb_read(`CSR_PRMD, rdata);
        check_value(rdata[2:0], 3'h7, "PRMD after exception");
        check_value(plv, 2'd0, "plv after exception");
        wb_read(`CSR_CRMD, rdata);
        check_value(rdata[2], 1'b0, "CRMD.IE after exception");
        wb_read(`CSR_ESTAT, rdata);
        check_value(rdata[21:16], ecode, "ESTAT exception code");
        check_value(rdata[30:22], esubcode, "ESTAT exception subcode");
        check_value(era, pc, "era output");
        wb_read(`CSR_BADV, rdata);
        check_value(rdata, badv, "BADV after exception");
        check_value(eentry, eentry_exp, "eentry output");
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
        check_value(plv, 2'd3, "plv after ertn");
        wb_read(`CSR_CRMD, rdata);
        check_value(rdata[2], 1'b1, "CRMD.IE after ertn");

        // interrupt pending from the hardware lines
        wb_write(`CSR_CRMD, 32'h7);
        wb_write(`CSR_ECFG, 32'h3fc);
        hwi_val = 8'($urandom_range(1, 255));
        check_value(irq_pending, 1'b0, "irq_pending before hwi");
        hwi = hwi_val;
        @(negedge clk);
        check_value(irq_pending, 1'b1, "irq_pending with hwi set");
        wb_read(`CSR_ESTAT, rdata);
        check_value(rdata[9:2], hwi_val, "ESTAT hardware interrupt bits");
        hwi = 8'b0;
        @(negedge clk);
        check_value(irq_pending, 1'b0, "irq_pending after hwi clear");
        wb_write(`CSR_CRMD, 32'h3);
        hwi = hwi_val;
        repeat (2) @(negedge clk);
        check_value(irq_pending, 1'b0, "irq_pending with IE clear");
        hwi = 8'b0;

        // one-shot timer
        wb_write(`CSR_TCFG, 32'h21);
        wait_estat_bit(11, "one-shot timer flag");
        wb_read(`CSR_TVAL, rdata);
        check_value(rdata, 32'hffff_ffff, "TVAL after one-shot");
        wb_write(`CSR_TICLR, 32'h1);
        wb_read(`CSR_ESTAT, rdata);
        check_value(rdata[11], 1'b0, "ESTAT timer bit after clear");
        wb_read(`CSR_TICLR, rdata);
        check_value(rdata, 32'h0, "TICLR read");

        // periodic timer fires again after a clear
        wb_write(`CSR_TCFG, 32'h43);
        wait_estat_bit(11, "first periodic timer flag");
        wb_write(`CSR_TICLR, 32'h1);
        wb_read(`CSR_ESTAT, rdata);
        check_value(rdata[11], 1'b0, "ESTAT timer bit after periodic clear");
        wait_estat_bit(11, "second periodic timer flag");
        wb_write(`CSR_TCFG, 32'h0);
        wb_write(`CSR_TICLR, 32'h1);

        gap         = $urandom_range(5, 40);
        count_start = stable_counter;
        repeat (gap) @(negedge clk);
        check_value(stable_counter - count_start, 64'(gap), "stable_counter step");

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/csr_macros.svh ====
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_ADDR_WIDTH 14
`define CSR_DATA_WIDTH 32

// privilege and exception registers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_EUEN    14'h002
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c

// address space and identity
`define CSR_ASID    14'h018
`define CSR_CPUID   14'h020

`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033

// timer
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

`define CSR_CPUID_VALUE 32'h4c41_0001

// writable bits per register
`define CSR_CRMD_MASK   32'h0000_01ff
`define CSR_PRMD_MASK   32'h0000_0007
`define CSR_EUEN_MASK   32'h0000_0001
`define CSR_ECFG_MASK   32'h0000_1fff
`define CSR_ESTAT_MASK  32'h0000_0003
`define CSR_EENTRY_MASK 32'hffff_ffc0
`define CSR_ASID_MASK   32'h0000_03ff
`define CSR_FULL_MASK   32'hffff_ffff

`endif

// ==== rtl/csr_pkg.sv ====
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

    // register bus address and data
    typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;
    typedef logic [`CSR_DATA_WIDTH-1:0] csr_data_t;

    // exception code fields as they sit in ESTAT
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

endpackage

`default_nettype wire

// ==== rtl/csr_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "csr_macros.svh"

module csr_regfile (
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      wr_en,
    input  wire csr_pkg::csr_addr_t  wr_addr,
    input  wire csr_pkg::csr_data_t  wr_data,
    input  wire csr_pkg::csr_addr_t  rd_addr,
    output csr_pkg::csr_data_t       rd_data,

    output csr_pkg::csr_data_t       eentry,
    output csr_pkg::csr_data_t       tid
);
    import csr_pkg::*;

    logic [25:0] eentry_q;
    logic        euen_q;
    logic [9:0]  asid_q;
    csr_data_t   tid_q;
    csr_data_t   save_q [4];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            eentry_q <= 26'b0;
            euen_q   <= 1'b0;
            asid_q   <= 10'b0;
            tid_q    <= '0;
        end
        else if (wr_en)
        begin
            case (wr_addr)
                `CSR_EENTRY: eentry_q <= wr_data[31:6];
                `CSR_EUEN:   euen_q   <= wr_data[0];
                `CSR_ASID:   asid_q   <= wr_data[9:0];
                `CSR_TID:    tid_q    <= wr_data;
                default:
                begin
                end
            endcase
        end
    end

    // scratch registers sit on four consecutive addresses
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            case (wr_addr)
                `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                    save_q[wr_addr[1:0]] <= wr_data;
                default:
                begin
                end
            endcase
        end
    end

    always_comb
    begin
        case (rd_addr)
            `CSR_EENTRY: rd_data = {eentry_q, 6'b0};
            `CSR_EUEN:   rd_data = {31'b0, euen_q};
            `CSR_ASID:   rd_data = {22'b0, asid_q};
            `CSR_CPUID:  rd_data = `CSR_CPUID_VALUE;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3:
                rd_data = save_q[rd_addr[1:0]];
            `CSR_TID:    rd_data = tid_q;
            default:     rd_data = '0;
        endcase
    end

    assign eentry = {eentry_q, 6'b0};
    assign tid    = tid_q;

endmodule

`default_nettype wire

// ==== rtl/csr_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "csr_macros.svh"

module csr_timer (
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      wr_en,
    input  wire csr_pkg::csr_addr_t  wr_addr,
    input  wire csr_pkg::csr_data_t  wr_data,
    input  wire csr_pkg::csr_addr_t  rd_addr,
    output csr_pkg::csr_data_t       rd_data,

    output logic                     timer_irq,
    output logic [63:0]              stable_counter
);
    import csr_pkg::*;

    csr_data_t tcfg_q;
    csr_data_t tval_q;
    logic      timer_en_q;
    logic      timer_flag_q;
    logic      tcfg_we;
    logic      ticlr_we;
    logic      timer_fire;

    assign tcfg_we    = wr_en && (wr_addr == `CSR_TCFG);
    assign ticlr_we   = wr_en && (wr_addr == `CSR_TICLR) && wr_data[0];
    assign timer_fire = timer_en_q && (tval_q == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tcfg_q       <= '0;
            timer_en_q   <= 1'b0;
            timer_flag_q <= 1'b0;
        end
        else
        begin
            if (tcfg_we)
            begin
                tcfg_q     <= wr_data;
                timer_en_q <= wr_data[0];
            end
            else if (timer_fire && !tcfg_q[1])
            begin
                // one-shot stops after it fires
                timer_en_q <= 1'b0;
            end

            if (ticlr_we)
                timer_flag_q <= 1'b0;
            else if (timer_fire)
                timer_flag_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tcfg_we)
            tval_q <= {wr_data[31:2], 2'b00};
        else if (timer_fire)
            tval_q <= tcfg_q[1] ? {tcfg_q[31:2], 2'b00} : '1;
        else if (timer_en_q)
            tval_q <= tval_q - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            stable_counter <= 64'b0;
        else
            stable_counter <= stable_counter + 64'd1;
    end

    // TICLR is write-only and falls to the default
    always_comb
    begin
        case (rd_addr)
            `CSR_TCFG: rd_data = tcfg_q;
            `CSR_TVAL: rd_data = tval_q;
            default:   rd_data = '0;
        endcase
    end

    assign timer_irq = timer_flag_q;

endmodule

`default_nettype wire

// ==== rtl/csr_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_top (
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire csr_pkg::csr_addr_t  wb_adr,
    input  wire csr_pkg::csr_data_t  wb_dat_w,
    output csr_pkg::csr_data_t       wb_dat_r,
    output logic                     wb_ack,

    input  wire                      exc_valid,
    input  wire csr_pkg::ecode_t     exc_ecode,
    input  wire csr_pkg::esubcode_t  exc_esubcode,
    input  wire csr_pkg::csr_data_t  exc_pc,
    input  wire csr_pkg::csr_data_t  exc_badv,
    input  wire                      exc_badv_valid,
    input  wire                      ertn,

    input  wire [7:0]                hwi,
    input  wire                      ipi,

    output logic                     irq_pending,
    output logic [1:0]               plv,
    output csr_pkg::csr_data_t       era,
    output csr_pkg::csr_data_t       eentry,
    output csr_pkg::csr_data_t       tid,
    output logic [63:0]              stable_counter
);
    import csr_pkg::*;

    logic      wr_en;
    csr_addr_t wr_addr;
    csr_data_t wr_data;
    csr_addr_t rd_addr;
    csr_data_t rd_data_trap;
    csr_data_t rd_data_timer;
    csr_data_t rd_data_regs;
    logic      timer_irq;

    csr_wb_port u_wb_port (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr),
        .rd_data_trap  (rd_data_trap),
        .rd_data_timer (rd_data_timer),
        .rd_data_regs  (rd_data_regs)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data_trap),
        .exc_valid      (exc_valid),
        .exc_ecode      (exc_ecode),
        .exc_esubcode   (exc_esubcode),
        .exc_pc         (exc_pc),
        .exc_badv       (exc_badv),
        .exc_badv_valid (exc_badv_valid),
        .ertn           (ertn),
        .hwi            (hwi),
        .ipi            (ipi),
        .timer_irq      (timer_irq),
        .irq_pending    (irq_pending),
        .plv            (plv),
        .era            (era)
    );

    csr_timer u_timer (
        .clk            (clk),
        .rst            (rst),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data_timer),
        .timer_irq      (timer_irq),
        .stable_counter (stable_counter)
    );

    csr_regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data_regs),
        .eentry  (eentry),
        .tid     (tid)
    );

endmodule

`default_nettype wire

// ==== rtl/csr_trap_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "csr_macros.svh"

module csr_trap_ctrl (
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      wr_en,
    input  wire csr_pkg::csr_addr_t  wr_addr,
    input  wire csr_pkg::csr_data_t  wr_data,
    input  wire csr_pkg::csr_addr_t  rd_addr,
    output csr_pkg::csr_data_t       rd_data,

    input  wire                      exc_valid,
    input  wire csr_pkg::ecode_t     exc_ecode,
    input  wire csr_pkg::esubcode_t  exc_esubcode,
    input  wire csr_pkg::csr_data_t  exc_pc,
    input  wire csr_pkg::csr_data_t  exc_badv,
    input  wire                      exc_badv_valid,
    input  wire                      ertn,

    input  wire [7:0]                hwi,
    input  wire                      ipi,
    input  wire                      timer_irq,
    output logic                     irq_pending,

    output logic [1:0]               plv,
    output csr_pkg::csr_data_t       era
);
    import csr_pkg::*;

    logic [8:0]  crmd_q;
    logic [2:0]  prmd_q;
    logic [12:0] ecfg_q;
    logic [1:0]  estat_swi_q;
    logic [9:0]  estat_int_q;
    ecode_t      estat_ecode_q;
    esubcode_t   estat_esub_q;
    csr_data_t   era_q;
    csr_data_t   badv_q;
    csr_data_t   estat_rd;
    logic        crmd_we;
    logic        prmd_we;
    logic        ecfg_we;
    logic        estat_we;
    logic        era_we;
    logic        badv_we;

    assign crmd_we  = wr_en && (wr_addr == `CSR_CRMD);
    assign prmd_we  = wr_en && (wr_addr == `CSR_PRMD);
    assign ecfg_we  = wr_en && (wr_addr == `CSR_ECFG);
    assign estat_we = wr_en && (wr_addr == `CSR_ESTAT);
    assign era_we   = wr_en && (wr_addr == `CSR_ERA);
    assign badv_we  = wr_en && (wr_addr == `CSR_BADV);

    // exception entry, then return, then software write
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            crmd_q <= 9'h008;
            prmd_q <= 3'b0;
        end
        else if (exc_valid)
        begin
            prmd_q      <= crmd_q[2:0];
            crmd_q[2:0] <= 3'b0;
        end
        else if (ertn)
        begin
            crmd_q[2:0] <= prmd_q;
        end
        else
        begin
            if (crmd_we)
                crmd_q <= wr_data[8:0];
            if (prmd_we)
                prmd_q <= wr_data[2:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ecfg_q        <= 13'b0;
            estat_swi_q   <= 2'b0;
            estat_int_q   <= 10'b0;
            estat_ecode_q <= '0;
            estat_esub_q  <= '0;
        end
        else
        begin
            estat_int_q <= {ipi, timer_irq, hwi};
            if (ecfg_we)
                ecfg_q <= wr_data[12:0];
            if (estat_we)
                estat_swi_q <= wr_data[1:0];
            if (exc_valid)
            begin
                estat_ecode_q <= exc_ecode;
                estat_esub_q  <= exc_esubcode;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (exc_valid)
            era_q <= exc_pc;
        else if (era_we)
            era_q <= wr_data;

        if (exc_valid && exc_badv_valid)
            badv_q <= exc_badv;
        else if (badv_we)
            badv_q <= wr_data;
    end

    // bit 10 is reserved
    assign estat_rd = {1'b0, estat_esub_q, estat_ecode_q, 3'b0,
                       estat_int_q[9:8], 1'b0, estat_int_q[7:0], estat_swi_q};

    always_comb
    begin
        case (rd_addr)
            `CSR_CRMD:  rd_data = {23'b0, crmd_q};
            `CSR_PRMD:  rd_data = {29'b0, prmd_q};
            `CSR_ECFG:  rd_data = {19'b0, ecfg_q};
            `CSR_ESTAT: rd_data = estat_rd;
            `CSR_ERA:   rd_data = era_q;
            `CSR_BADV:  rd_data = badv_q;
            default:    rd_data = '0;
        endcase
    end

    assign irq_pending = crmd_q[2] && ((estat_rd[12:0] & ecfg_q) != 13'b0);
    assign plv         = crmd_q[1:0];
    assign era         = era_q;

endmodule

`default_nettype wire

// ==== rtl/csr_wb_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_wb_port (
    input  wire                      clk,
    input  wire                      rst,

    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire csr_pkg::csr_addr_t  wb_adr,
    input  wire csr_pkg::csr_data_t  wb_dat_w,
    output csr_pkg::csr_data_t       wb_dat_r,
    output logic                     wb_ack,

    output logic                     wr_en,
    output csr_pkg::csr_addr_t       wr_addr,
    output csr_pkg::csr_data_t       wr_data,
    output csr_pkg::csr_addr_t       rd_addr,

    input  wire csr_pkg::csr_data_t  rd_data_trap,
    input  wire csr_pkg::csr_data_t  rd_data_timer,
    input  wire csr_pkg::csr_data_t  rd_data_regs
);
    import csr_pkg::*;

    logic      req_open;
    csr_data_t rd_data_all;

    // a request stays open until the ack cycle, which closes it for one cycle
    assign req_open = wb_cyc && wb_stb && !wb_ack;

    // blocks return zero outside their own addresses
    assign rd_data_all = rd_data_trap | rd_data_timer | rd_data_regs;

    // write strobe lands on the edge where ack rises
    assign wr_en   = req_open && wb_we;
    assign wr_addr = wb_adr;
    assign wr_data = wb_dat_w;
    assign rd_addr = wb_adr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack <= 1'b0;
        end
        else
        begin
            wb_ack <= req_open;
        end
    end

    // captures the pre-edge register value
    always_ff @(posedge clk)
    begin
        if (req_open && !wb_we)
        begin
            wb_dat_r <= rd_data_all;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/csr_pkg.sv
rtl/csr_wb_port.sv
rtl/csr_trap_ctrl.sv
rtl/csr_timer.sv
rtl/csr_regfile.sv
rtl/csr_top.sv
dv/csr_tb.sv
